/* verilog/dispatch_pkg.sv */
// ----------------------------------------------------------
// Dispatch package
// Widths, field offsets, unit codes and word types shared
// by the dispatch stage of the SIMT core
// ----------------------------------------------------------
`default_nettype none

package dispatch_pkg;

    // Warp geometry
    localparam int THREAD_CNT = 4;
    localparam int TID_W      = 2;
    localparam int XLEN       = 32;

    // Execution unit codes
    localparam int EX_W      = 2;
    localparam int NUM_UNITS = 4;

    localparam logic [EX_W-1:0] EX_ALU = 2'd0;
    localparam logic [EX_W-1:0] EX_LSU = 2'd1;
    localparam logic [EX_W-1:0] EX_FPU = 2'd2;
    localparam logic [EX_W-1:0] EX_SFU = 2'd3;

    // Issue word field widths
    localparam int UUID_W = 8;
    localparam int WID_W  = 2;
    localparam int OP_W   = 4;
    localparam int RD_W   = 5;
    localparam int DATA_W = THREAD_CNT * XLEN;

    // Field offsets, counted from bit 0 upwards
    localparam int RS2_LSB   = 0;
    localparam int RS1_LSB   = RS2_LSB + DATA_W;
    localparam int WB_LSB    = RS1_LSB + DATA_W;
    localparam int RD_LSB    = WB_LSB + 1;
    localparam int PC_LSB    = RD_LSB + RD_W;
    localparam int OP_LSB    = PC_LSB + XLEN;
    localparam int TMASK_LSB = OP_LSB + OP_W;
    localparam int WID_LSB   = TMASK_LSB + THREAD_CNT;
    localparam int UUID_LSB  = WID_LSB + WID_W;

    localparam int ISSUE_W    = UUID_LSB + UUID_W;
    localparam int DISPATCH_W = ISSUE_W + TID_W;

    // Stall counter width, counters wrap
    localparam int PERF_W = 16;

    typedef logic [EX_W-1:0]       ex_type_t;
    typedef logic [TID_W-1:0]      tid_t;
    typedef logic [THREAD_CNT-1:0] tmask_t;
    typedef logic [ISSUE_W-1:0]    issue_word_t;
    // Issue word with last active thread index in the low bits
    typedef logic [DISPATCH_W-1:0] dispatch_word_t;
    typedef logic [PERF_W-1:0]     perf_cnt_t;

endpackage

`default_nettype wire

/* verilog/last_thread_finder.sv */
// ----------------------------------------------------------
// Last thread finder
// Priority encoder giving the index of the highest active
// thread in a warp thread mask
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module last_thread_finder import dispatch_pkg::*; (
    input  wire tmask_t tmask,
    output tid_t        last_tid
);

    logic found;

    // Walk down from the top thread, first hit wins
    always_comb begin
        found    = 1'b0;
        last_tid = '0;
        for (int i = THREAD_CNT - 1; i >= 0; i--) begin
            if (!found && tmask[i]) begin
                last_tid = tid_t'(i);
                found    = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dispatch_router.sv */
// ----------------------------------------------------------
// Dispatch router
// Decodes the unit type of the issued instruction, appends
// the last active thread and returns the ready of the
// selected unit buffer
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatch_router import dispatch_pkg::*; (
    input  wire logic                  in_valid,
    output logic                       in_ready,
    input  wire ex_type_t              in_ex_type,
    input  wire issue_word_t           in_data,

    output logic [NUM_UNITS-1:0]       unit_valid,
    input  wire logic [NUM_UNITS-1:0]  unit_ready,
    output dispatch_word_t             unit_data
);

    tmask_t tmask;
    tid_t   last_tid;

    assign tmask = in_data[TMASK_LSB +: THREAD_CNT];

    last_thread_finder last_thread_finder_inst (
        .tmask    (tmask),
        .last_tid (last_tid)
    );

    // One-hot valid towards the unit buffers
    always_comb begin
        for (int i = 0; i < NUM_UNITS; i++) begin
            unit_valid[i] = in_valid && (in_ex_type == ex_type_t'(i));
        end
    end

    // All buffers see the same word, only one gets a valid
    assign unit_data = {in_data, last_tid};

    // Input stalls on the selected buffer only
    assign in_ready = unit_ready[in_ex_type];

    // An issued instruction always carries at least one live thread
    a_tmask_nonzero: assert final (!in_valid || (tmask != '0))
        else $error("dispatch_router: valid instruction with empty thread mask");

endmodule

`default_nettype wire

/* verilog/dispatch_buffer.sv */
// ----------------------------------------------------------
// Dispatch buffer
// Two-entry elastic buffer with a registered output stage,
// valid/ready handshake on both sides
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatch_buffer import dispatch_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,

    input  wire logic           in_valid,
    output logic                in_ready,
    input  wire dispatch_word_t in_data,

    output logic                out_valid,
    input  wire logic           out_ready,
    output dispatch_word_t      out_data
);

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_ONE,
        ST_TWO
    } buf_state_t;

    buf_state_t     state;
    buf_state_t     state_next;
    dispatch_word_t head_q;
    dispatch_word_t skid_q;
    logic           push;
    logic           pop;

    // Ready depends on state only, so no comb path from out_ready
    assign in_ready  = (state != ST_TWO);
    assign out_valid = (state != ST_EMPTY);
    assign out_data  = head_q;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        state_next = state;
        case (state)
            ST_EMPTY: if (push) state_next = ST_ONE;
            ST_ONE: begin
                if (push && !pop) begin
                    state_next = ST_TWO;
                end else if (pop && !push) begin
                    state_next = ST_EMPTY;
                end
            end
            ST_TWO:   if (pop) state_next = ST_ONE;
            default:  state_next = ST_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // Head feeds the unit, skid catches the second word
    always_ff @(posedge clk) begin
        case (state)
            ST_EMPTY: if (push) head_q <= in_data;
            ST_ONE: begin
                if (push && pop) begin
                    head_q <= in_data;
                end else if (push) begin
                    skid_q <= in_data;
                end
            end
            ST_TWO:   if (pop) head_q <= skid_q;
            default:  ;
        endcase
    end

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // A full buffer keeps its second word until the unit takes one
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        (state == ST_TWO) && !pop |=> (state == ST_TWO) && $stable(skid_q));

endmodule

`default_nettype wire

/* verilog/stall_counters.sv */
// ----------------------------------------------------------
// Stall counters
// One wrapping counter per execution unit, counting cycles
// the input is held back, with a registered read port
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stall_counters import dispatch_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,

    // Observed input handshake
    input  wire logic     in_valid,
    input  wire logic     in_ready,
    input  wire ex_type_t in_ex_type,

    // Read port
    input  wire ex_type_t cnt_addr,
    output perf_cnt_t     cnt_data
);

    perf_cnt_t counts [NUM_UNITS];
    logic      stall;

    assign stall = in_valid && !in_ready;

    // Charge the stall to the unit the held instruction waits for
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                counts[i] <= '0;
            end
        end else if (stall) begin
            counts[in_ex_type] <= counts[in_ex_type] + perf_cnt_t'(1);
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_data <= '0;
        end else begin
            cnt_data <= counts[cnt_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/dispatch_top.sv */
// ----------------------------------------------------------
// Dispatch top
// Router, one elastic buffer per execution unit and the
// stall counter block of the dispatch stage
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatch_top import dispatch_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset,

    // Issued instruction
    input  wire logic           in_valid,
    output logic                in_ready,
    input  wire ex_type_t       in_ex_type,
    input  wire issue_word_t    in_data,

    // Unit queues
    output logic                alu_valid,
    input  wire logic           alu_ready,
    output dispatch_word_t      alu_data,
    output logic                lsu_valid,
    input  wire logic           lsu_ready,
    output dispatch_word_t      lsu_data,
    output logic                fpu_valid,
    input  wire logic           fpu_ready,
    output dispatch_word_t      fpu_data,
    output logic                sfu_valid,
    input  wire logic           sfu_ready,
    output dispatch_word_t      sfu_data,

    // Stall counter read port
    input  wire ex_type_t       cnt_addr,
    output perf_cnt_t           cnt_data
);

    logic [NUM_UNITS-1:0] unit_valid;
    logic [NUM_UNITS-1:0] unit_ready;
    dispatch_word_t       unit_data;

    dispatch_router dispatch_router_inst (
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_ex_type (in_ex_type),
        .in_data    (in_data),
        .unit_valid (unit_valid),
        .unit_ready (unit_ready),
        .unit_data  (unit_data)
    );

    dispatch_buffer alu_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (unit_valid[EX_ALU]),
        .in_ready  (unit_ready[EX_ALU]),
        .in_data   (unit_data),
        .out_valid (alu_valid),
        .out_ready (alu_ready),
        .out_data  (alu_data)
    );

    dispatch_buffer lsu_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (unit_valid[EX_LSU]),
        .in_ready  (unit_ready[EX_LSU]),
        .in_data   (unit_data),
        .out_valid (lsu_valid),
        .out_ready (lsu_ready),
        .out_data  (lsu_data)
    );

    dispatch_buffer fpu_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (unit_valid[EX_FPU]),
        .in_ready  (unit_ready[EX_FPU]),
        .in_data   (unit_data),
        .out_valid (fpu_valid),
        .out_ready (fpu_ready),
        .out_data  (fpu_data)
    );

    dispatch_buffer sfu_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (unit_valid[EX_SFU]),
        .in_ready  (unit_ready[EX_SFU]),
        .in_data   (unit_data),
        .out_valid (sfu_valid),
        .out_ready (sfu_ready),
        .out_data  (sfu_data)
    );

    // Watches the input handshake only
    stall_counters stall_counters_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_ex_type (in_ex_type),
        .cnt_addr   (cnt_addr),
        .cnt_data   (cnt_data)
    );

endmodule

`default_nettype wire

/* include/dispatch_vectors.svh */
// ----------------------------------------------------------
// Dispatch stimulus table
// Issued instructions and the unit ready pattern held
// while each row is presented
// ----------------------------------------------------------
`ifndef DISPATCH_VECTORS_SVH
`define DISPATCH_VECTORS_SVH

// Included inside a module that imports dispatch_pkg
typedef struct packed {
    ex_type_t          ex;
    tmask_t            tmask;
    logic [OP_W-1:0]   op;
    logic [RD_W-1:0]   rd;
    logic              wb;
    // Unit readies from bit 0 ALU up to bit 3 SFU
    logic [NUM_UNITS-1:0] rdy;
} vec_row_t;

localparam int VEC_ROWS = 24;

localparam vec_row_t VEC_TABLE [VEC_ROWS] = '{
    // Single active thread with every unit free
    '{EX_ALU, 4'b0001, 4'h1, 5'd1,  1'b1, 4'b1111},
    '{EX_LSU, 4'b0010, 4'h2, 5'd2,  1'b1, 4'b1111},
    '{EX_FPU, 4'b0100, 4'h3, 5'd3,  1'b0, 4'b1111},
    '{EX_SFU, 4'b1000, 4'h4, 5'd4,  1'b1, 4'b1111},
    // Several threads and a full warp
    '{EX_ALU, 4'b0011, 4'h5, 5'd5,  1'b1, 4'b1111},
    '{EX_LSU, 4'b0110, 4'h6, 5'd6,  1'b0, 4'b1111},
    '{EX_FPU, 4'b1111, 4'h7, 5'd7,  1'b1, 4'b1111},
    '{EX_SFU, 4'b1010, 4'h8, 5'd8,  1'b1, 4'b1111},
    // ALU held off, third word waits for the drain
    '{EX_ALU, 4'b0101, 4'h9, 5'd9,  1'b1, 4'b1110},
    '{EX_ALU, 4'b1100, 4'ha, 5'd10, 1'b0, 4'b1110},
    '{EX_ALU, 4'b0111, 4'hb, 5'd11, 1'b1, 4'b1111},
    // LSU held off, FPU passes meanwhile
    '{EX_LSU, 4'b1001, 4'hc, 5'd12, 1'b1, 4'b1101},
    '{EX_LSU, 4'b1111, 4'hd, 5'd13, 1'b1, 4'b1101},
    '{EX_FPU, 4'b0001, 4'he, 5'd14, 1'b0, 4'b1101},
    '{EX_LSU, 4'b0100, 4'hf, 5'd15, 1'b1, 4'b1111},
    // FPU held off
    '{EX_FPU, 4'b1011, 4'h0, 5'd16, 1'b1, 4'b1011},
    '{EX_FPU, 4'b0110, 4'h1, 5'd17, 1'b1, 4'b1011},
    '{EX_FPU, 4'b1110, 4'h2, 5'd18, 1'b0, 4'b1111},
    // SFU held off
    '{EX_SFU, 4'b0001, 4'h3, 5'd19, 1'b1, 4'b0111},
    '{EX_SFU, 4'b1101, 4'h4, 5'd20, 1'b1, 4'b0111},
    '{EX_SFU, 4'b0010, 4'h5, 5'd21, 1'b0, 4'b1111},
    // ALU held off once more, so its stall count differs
    '{EX_ALU, 4'b1000, 4'h6, 5'd22, 1'b1, 4'b1110},
    '{EX_ALU, 4'b1111, 4'h7, 5'd23, 1'b1, 4'b1110},
    '{EX_ALU, 4'b0011, 4'h8, 5'd24, 1'b0, 4'b1111}
};

`endif

/* tb/dispatch_tb.sv */
// ----------------------------------------------------------
// Dispatch stage testbench
// Table-driven issue stream with per-unit back-pressure,
// reference queues per unit and stall counter readback
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb import dispatch_pkg::*; ();

`include "dispatch_vectors.svh"

    localparam int CLK_PERIOD = 40;
    localparam int MAX_CYCLES = VEC_ROWS * 20 + 100;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_ready;
    ex_type_t             in_ex_type;
    issue_word_t          in_data;
    ex_type_t             cnt_addr;
    perf_cnt_t            cnt_data;
    logic [NUM_UNITS-1:0] unit_rdy;

    logic                 alu_valid;
    logic                 lsu_valid;
    logic                 fpu_valid;
    logic                 sfu_valid;
    dispatch_word_t       alu_data;
    dispatch_word_t       lsu_data;
    dispatch_word_t       fpu_data;
    dispatch_word_t       sfu_data;

    // Unit outputs gathered by unit code
    logic [NUM_UNITS-1:0] unit_vld;
    dispatch_word_t       unit_dat [NUM_UNITS];

    dispatch_word_t       exp_q [NUM_UNITS][$];
    int                   stall_seen [NUM_UNITS];
    int                   err_cnt;
    int                   cycle_cnt;

    dispatch_top dispatch_top_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_ex_type (in_ex_type),
        .in_data    (in_data),
        .alu_valid  (alu_valid),
        .alu_ready  (unit_rdy[EX_ALU]),
        .alu_data   (alu_data),
        .lsu_valid  (lsu_valid),
        .lsu_ready  (unit_rdy[EX_LSU]),
        .lsu_data   (lsu_data),
        .fpu_valid  (fpu_valid),
        .fpu_ready  (unit_rdy[EX_FPU]),
        .fpu_data   (fpu_data),
        .sfu_valid  (sfu_valid),
        .sfu_ready  (unit_rdy[EX_SFU]),
        .sfu_data   (sfu_data),
        .cnt_addr   (cnt_addr),
        .cnt_data   (cnt_data)
    );

    always_comb begin
        unit_vld[EX_ALU] = alu_valid;
        unit_vld[EX_LSU] = lsu_valid;
        unit_vld[EX_FPU] = fpu_valid;
        unit_vld[EX_SFU] = sfu_valid;
        unit_dat[EX_ALU] = alu_data;
        unit_dat[EX_LSU] = lsu_data;
        unit_dat[EX_FPU] = fpu_data;
        unit_dat[EX_SFU] = sfu_data;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: no completion within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic string unit_name(input int u);
        case (u)
            0:       return "alu";
            1:       return "lsu";
            2:       return "fpu";
            default: return "sfu";
        endcase
    endfunction

    // Highest active thread wins
    function automatic tid_t highest_thread(input tmask_t m);
        if (m[3]) return 2'd3;
        if (m[2]) return 2'd2;
        if (m[1]) return 2'd1;
        return 2'd0;
    endfunction

    function automatic issue_word_t build_word(input int r);
        issue_word_t w;
        w = '0;
        w[UUID_LSB +: UUID_W]      = r[UUID_W-1:0];
        w[WID_LSB +: WID_W]        = r[WID_W-1:0];
        w[TMASK_LSB +: THREAD_CNT] = VEC_TABLE[r].tmask;
        w[OP_LSB +: OP_W]          = VEC_TABLE[r].op;
        w[PC_LSB +: XLEN]          = 32'h0000_1000 + 32'(r * 4);
        w[RD_LSB +: RD_W]          = VEC_TABLE[r].rd;
        w[WB_LSB]                  = VEC_TABLE[r].wb;
        for (int t = 0; t < THREAD_CNT; t++) begin
            w[RS1_LSB + t * XLEN +: XLEN] = $urandom();
            w[RS2_LSB + t * XLEN +: XLEN] = $urandom();
        end
        return w;
    endfunction

    task automatic report_error(input string name, input logic [DISPATCH_W-1:0] exp,
                                input logic [DISPATCH_W-1:0] act);
        $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
        err_cnt++;
    endtask

    // Drive on the falling edge and check once things settle
    task automatic tick(input logic valid, input ex_type_t ex, input issue_word_t word,
                        input dispatch_word_t exp_word, input logic [NUM_UNITS-1:0] rdy,
                        input string name, output logic accepted);
        int   occ [NUM_UNITS];
        logic exp_rdy;
        @(negedge clk);
        in_valid   = valid;
        in_ex_type = ex;
        in_data    = word;
        unit_rdy   = rdy;
        #(CLK_PERIOD / 4);
        for (int u = 0; u < NUM_UNITS; u++) begin
            occ[u] = exp_q[u].size();
        end
        // Valid must track buffer occupancy, so a word shows one cycle after acceptance
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (unit_vld[u] !== (occ[u] != 0)) begin
                report_error({name, " ", unit_name(u), "_valid"}, occ[u] != 0, unit_vld[u]);
            end else if (occ[u] != 0) begin
                if (unit_dat[u] !== exp_q[u][0]) begin
                    report_error({name, " ", unit_name(u), "_data"}, exp_q[u][0], unit_dat[u]);
                end
                if (rdy[u]) begin
                    void'(exp_q[u].pop_front());
                end
            end
        end
        exp_rdy = (occ[ex] < 2);
        if (in_ready !== exp_rdy) begin
            report_error({name, " in_ready"}, exp_rdy, in_ready);
        end
        if (valid && !in_ready) begin
            stall_seen[ex]++;
        end
        accepted = valid && in_ready;
        if (accepted) begin
            exp_q[ex].push_back(exp_word);
        end
    endtask

    task automatic read_counter(input int u, input perf_cnt_t exp, input string name);
        perf_cnt_t held_exp;
        @(negedge clk);
        held_exp = perf_cnt_t'(stall_seen[cnt_addr]);
        cnt_addr = ex_type_t'(u);
        // Read port still shows the previous address before the edge
        #(CLK_PERIOD / 4);
        if (cnt_data !== held_exp) begin
            report_error({name, " early counter ", unit_name(u)}, held_exp, cnt_data);
        end
        @(negedge clk);
        if (cnt_data !== exp) begin
            report_error({name, " counter ", unit_name(u)}, exp, cnt_data);
        end
    endtask

    function automatic int pending_words();
        int n;
        n = 0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            n += exp_q[u].size();
        end
        return n;
    endfunction

    initial begin
        issue_word_t    word;
        dispatch_word_t exp_word;
        logic           accepted;
        void'($urandom(32'h1c89));
        clk        = 1'b0;
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_ex_type = EX_ALU;
        in_data    = '0;
        cnt_addr   = EX_ALU;
        unit_rdy   = '1;
        err_cnt    = 0;
        cycle_cnt  = 0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            stall_seen[u] = 0;
        end

        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Idle state straight out of reset
        tick(1'b0, EX_ALU, '0, '0, 4'b1111, "after reset", accepted);
        for (int u = 0; u < NUM_UNITS; u++) begin
            read_counter(u, '0, "after reset");
        end

        for (int r = 0; r < VEC_ROWS; r++) begin
            word     = build_word(r);
            exp_word = {word, highest_thread(VEC_TABLE[r].tmask)};
            accepted = 1'b0;
            while (!accepted) begin
                tick(1'b1, VEC_TABLE[r].ex, word, exp_word, VEC_TABLE[r].rdy,
                     $sformatf("row %0d", r), accepted);
            end
        end

        // Let every buffer drain, then confirm all valids drop
        while (pending_words() != 0) begin
            tick(1'b0, EX_ALU, '0, '0, 4'b1111, "drain", accepted);
        end
        tick(1'b0, EX_ALU, '0, '0, 4'b1111, "idle", accepted);

        for (int u = 0; u < NUM_UNITS; u++) begin
            read_counter(u, perf_cnt_t'(stall_seen[u]), "final");
        end

        $display("Checks done with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
verilog/dispatch_pkg.sv
verilog/last_thread_finder.sv
verilog/dispatch_router.sv
verilog/dispatch_buffer.sv
verilog/stall_counters.sv
verilog/dispatch_top.sv
tb/dispatch_tb.sv

/* Bender.yml */
package:
  name: dispatch

sources:
  - files:
      - verilog/dispatch_pkg.sv
      - verilog/last_thread_finder.sv
      - verilog/dispatch_router.sv
      - verilog/dispatch_buffer.sv
      - verilog/stall_counters.sv
      - verilog/dispatch_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/dispatch_tb.sv
